//--- decode_dispatch.f
source/decode_pkg.sv
source/inst_decoder.sv
source/decode_queue.sv
source/fu_dispatch.sv
source/decode_dispatch_top.sv
bench/decode_dispatch_checker.sv
bench/decode_dispatch_tb.sv

//--- Bender.yml
package:
  name: decode_dispatch

sources:
  - source/decode_pkg.sv
  - source/inst_decoder.sv
  - source/decode_queue.sv
  - source/fu_dispatch.sv
  - source/decode_dispatch_top.sv
  - target: test
    files:
      - bench/decode_dispatch_checker.sv
      - bench/decode_dispatch_tb.sv

//--- bench/decode_dispatch_tb.sv
`default_nettype none

module decode_dispatch_tb;
    import decode_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int FU_CREDITS  = 2;

    localparam fu_op_t ALU_BY_F3 [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                         ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    localparam fu_op_t LOAD_BY_F3 [8] = '{MEM_LB, MEM_LH, MEM_LW, MEM_LB,
                                          MEM_LBU, MEM_LHU, MEM_LB, MEM_LB};
    localparam fu_op_t STORE_BY_F3 [3] = '{MEM_SB, MEM_SH, MEM_SW};
    localparam fu_op_t BRANCH_BY_F3 [8] = '{BRA_BEQ, BRA_BNE, BRA_BEQ, BRA_BEQ,
                                            BRA_BLT, BRA_BGE, BRA_BLTU, BRA_BGEU};

    logic       clk;
    logic       rst;
    logic       fetch_valid;
    fetch_pkt_t fetch_pkt;
    logic       fetch_credit;
    logic       alu_valid;
    logic       lsq_valid;
    logic       bra_valid;
    logic       illegal_valid;
    uop_t       alu_uop;
    uop_t       lsq_uop;
    uop_t       bra_uop;
    logic       alu_credit;
    logic       lsq_credit;
    logic       bra_credit;
    xlen_t      illegal_pc;

    string      test_name;
    xlen_t      next_pc;
    int         sent;
    int         returned;
    int         cycles;
    int         ill_seen;
    int         seen [3];
    int         owed [3];
    bit         auto_ret [3];
    logic [2:0] pulse;
    uop_t       exp_q [3][$];
    xlen_t      ill_q [$];
    inst_t      burst_q [$];

    decode_dispatch_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_uop(input string what, input uop_t exp, input uop_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                                test_name, what, exp, act));
        end
    endtask

    task automatic check_pc(input string what, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                                test_name, what, exp, act));
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("CHECK FAILED %s %s: expected %0d, actual %0d",
                                test_name, what, exp, act));
        end
    endtask

    // Random register fields, fixed funct7/funct3/opcode
    function automatic inst_t enc(input logic [6:0] f7, input logic [2:0] f3,
                                  input opcode_t opc);
        return {f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), opc};
    endfunction

    function automatic inst_t enc_any(input logic [2:0] f3, input opcode_t opc);
        return enc(7'($urandom), f3, opc);
    endfunction

    function automatic inst_t enc_upper(input opcode_t opc);
        return {25'($urandom), opc};
    endfunction

    // Reference decode, straight from the RV32I formats
    function automatic uop_t expected_uop(input xlen_t pc, input inst_t inst);
        uop_t       u;
        logic [2:0] f3;
        logic [6:0] f7;
        xlen_t      imm_i;
        xlen_t      imm_u;
        f3    = inst[14:12];
        f7    = inst[31:25];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_u = {inst[31:12], 12'h000};
        u     = '0;
        u.pc  = pc;
        u.rd  = inst[11:7];
        u.rs1 = inst[19:15];
        u.rs2 = inst[24:20];
        case (inst[6:0])
            OPC_R: begin
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                    u.fu        = FU_ALU;
                    u.fu_op     = ALU_BY_F3[f3];
                    if (f7 == 7'h20) begin
                        u.fu_op = (f3 == 3'd0) ? ALU_SUB : ALU_SRA;
                    end
                    u.reg_write = 1'b1;
                    u.op_a_sel  = OPSEL_REG;
                    u.op_b_sel  = OPSEL_REG;
                end
            end
            OPC_I_LOGIC: begin
                if ((f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 ||
                    (f3 == 3'd5 && f7 == 7'h20)) begin
                    u.fu        = FU_ALU;
                    u.fu_op     = (f3 == 3'd5 && f7 == 7'h20) ? ALU_SRA : ALU_BY_F3[f3];
                    u.reg_write = 1'b1;
                    u.op_a_sel  = OPSEL_REG;
                    u.op_b_sel  = OPSEL_IMM;
                    u.imm       = imm_i;
                end
            end
            OPC_LUI, OPC_AUIPC: begin
                u.fu        = FU_ALU;
                u.fu_op     = (inst[6:0] == OPC_LUI) ? ALU_OUTB : ALU_ADD;
                u.reg_write = 1'b1;
                u.op_a_sel  = (inst[6:0] == OPC_LUI) ? OPSEL_ZERO : OPSEL_PC;
                u.imm       = imm_u;
            end
            OPC_I_MEM: begin
                if (f3 != 3'd3 && f3 < 3'd6) begin
                    u.fu        = FU_LSQ;
                    u.fu_op     = LOAD_BY_F3[f3];
                    u.reg_write = 1'b1;
                    u.op_a_sel  = OPSEL_REG;
                    u.imm       = imm_i;
                end
            end
            OPC_S: begin
                if (f3 < 3'd3) begin
                    u.fu       = FU_LSQ;
                    u.fu_op    = STORE_BY_F3[f3];
                    u.op_a_sel = OPSEL_REG;
                    u.imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                end
            end
            OPC_B: begin
                if (f3 != 3'd2 && f3 != 3'd3) begin
                    u.fu    = FU_BRA;
                    u.fu_op = BRANCH_BY_F3[f3];
                    u.imm   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                end
            end
            OPC_JAL: begin
                u.fu        = FU_BRA;
                u.fu_op     = BRA_JAL;
                u.reg_write = 1'b1;
                u.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            OPC_JALR: begin
                if (f3 == 3'd0) begin
                    u.fu        = FU_BRA;
                    u.fu_op     = BRA_JALR;
                    u.reg_write = 1'b1;
                    u.imm       = imm_i;
                end
            end
            default: ;
        endcase
        return u;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic send_inst(input inst_t inst);
        uop_t exp;
        exp = expected_uop(next_pc, inst);
        while (QUEUE_DEPTH - sent + returned == 0) begin
            next_cycle();
        end
        // Port index follows the unit encoding, ALU first
        if (exp.fu == FU_NONE) begin
            ill_q.push_back(next_pc);
        end else begin
            exp_q[int'(exp.fu) - 1].push_back(exp);
        end
        fetch_valid    = 1'b1;
        fetch_pkt.pc   = next_pc;
        fetch_pkt.inst = inst;
        sent++;
        next_pc += 32'd4;
        next_cycle();
        fetch_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + ill_q.size() != 0) begin
            next_cycle();
        end
        repeat (3) next_cycle();
    endtask

    task automatic take_uop(input int unit, input string port, input uop_t act);
        if (exp_q[unit].size() == 0) begin
            abort_run($sformatf("%s delivered a uop that was never sent in test %s",
                                port, test_name));
        end
        check_uop(port, exp_q[unit].pop_front(), act);
        seen[unit]++;
        if (auto_ret[unit]) begin
            owed[unit]++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (fetch_credit) begin
                returned++;
            end
            if (alu_valid) begin
                take_uop(0, "alu_uop", alu_uop);
            end
            if (lsq_valid) begin
                take_uop(1, "lsq_uop", lsq_uop);
            end
            if (bra_valid) begin
                take_uop(2, "bra_uop", bra_uop);
            end
            if (illegal_valid) begin
                if (ill_q.size() == 0) begin
                    abort_run("illegal port reported an instruction that was never sent");
                end
                check_pc("illegal_pc", ill_q.pop_front(), illegal_pc);
                ill_seen++;
            end
        end
    end

    always @(posedge clk) begin
        if (u_dut.u_checker.fail_count != 0) begin
            abort_run("An assertion in the bound checker failed");
        end
    end

    // One credit pulse per cycle for each unit that is owed one
    always @(posedge clk) begin
        #10;
        for (int i = 0; i < 3; i++) begin
            pulse[i] = (owed[i] > 0);
            if (pulse[i]) begin
                owed[i]--;
            end
        end
        alu_credit = pulse[0];
        lsq_credit = pulse[1];
        bra_credit = pulse[2];
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 200 * sent + 1000) begin
                abort_run($sformatf("Timeout after %0d cycles with %0d instructions sent",
                                    cycles, sent));
            end
        end
    end

    task automatic idle_test();
        int activity;
        test_name = "idle";
        activity  = 0;
        repeat (20) begin
            next_cycle();
            activity += alu_valid + lsq_valid + bra_valid + illegal_valid + fetch_credit;
        end
        check_count("outputs raised", 0, activity);
    endtask

    task automatic alu_test();
        test_name = "alu_decode";
        for (int f3 = 0; f3 < 8; f3++) begin
            send_inst(enc(7'h00, 3'(f3), OPC_R));
        end
        send_inst(enc(7'h20, 3'd0, OPC_R));
        send_inst(enc(7'h20, 3'd5, OPC_R));
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 != 1 && f3 != 5) begin
                send_inst(enc_any(3'(f3), OPC_I_LOGIC));
            end
        end
        send_inst(enc(7'h00, 3'd1, OPC_I_LOGIC));
        send_inst(enc(7'h00, 3'd5, OPC_I_LOGIC));
        send_inst(enc(7'h20, 3'd5, OPC_I_LOGIC));
        send_inst(enc_upper(OPC_LUI));
        send_inst(enc_upper(OPC_AUIPC));
        drain();
    endtask

    task automatic lsq_test();
        test_name = "lsq_decode";
        for (int f3 = 0; f3 < 6; f3++) begin
            if (f3 != 3) begin
                send_inst(enc_any(3'(f3), OPC_I_MEM));
            end
            if (f3 < 3) begin
                send_inst(enc_any(3'(f3), OPC_S));
            end
        end
        drain();
    endtask

    task automatic branch_test();
        test_name = "branch_decode";
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 != 2 && f3 != 3) begin
                send_inst(enc_any(3'(f3), OPC_B));
            end
        end
        send_inst(enc_upper(OPC_JAL));
        send_inst(enc_any(3'd0, OPC_JALR));
        drain();
    endtask

    task automatic backpressure_test();
        int sent0;
        int ret0;
        int seen0;
        int target;
        test_name = "backpressure";
        burst_q.delete();
        for (int k = 0; k < QUEUE_DEPTH + FU_CREDITS + 1; k++) begin
            if (k % 2 == 0) begin
                burst_q.push_back(enc_any(3'd0, OPC_I_LOGIC));
            end else begin
                burst_q.push_back(enc(7'h00, 3'($urandom), OPC_R));
            end
        end
        auto_ret[0] = 1'b0;
        sent0 = sent;
        ret0  = returned;
        seen0 = seen[0];
        fork
            foreach (burst_q[k]) begin
                send_inst(burst_q[k]);
            end
        join_none
        while (seen[0] - seen0 < FU_CREDITS) begin
            next_cycle();
        end
        // Let the stall settle before counting
        repeat (10) next_cycle();
        check_count("alu uops delivered", FU_CREDITS, seen[0] - seen0);
        check_count("fetch credits returned", FU_CREDITS, returned - ret0);
        check_count("instructions sent", QUEUE_DEPTH + FU_CREDITS, sent - sent0);
        for (int k = FU_CREDITS; k < burst_q.size(); k++) begin
            target = seen[0] + 1;
            owed[0]++;
            while (seen[0] < target) begin
                next_cycle();
            end
        end
        owed[0] += FU_CREDITS;
        auto_ret[0] = 1'b1;
        wait fork;
        drain();
    endtask

    // Each unit spends its last credit after the illegal ones have passed
    task automatic illegal_test();
        int ill0;
        test_name = "illegal";
        ill0 = ill_seen;
        for (int i = 0; i < 3; i++) begin
            auto_ret[i] = 1'b0;
        end
        send_inst(enc_any(3'd6, OPC_I_LOGIC));
        send_inst(enc_any(3'd2, OPC_I_MEM));
        send_inst(enc_any(3'd1, OPC_B));
        send_inst(32'h0000_0073);
        send_inst(enc_upper(7'h7f));
        send_inst(enc(7'h01, 3'($urandom), OPC_R));
        send_inst(enc(7'h00, 3'd0, OPC_R));
        send_inst(enc_any(3'd2, OPC_S));
        send_inst(enc_any(3'd0, OPC_JALR));
        drain();
        check_count("illegal reports", 3, ill_seen - ill0);
        for (int i = 0; i < 3; i++) begin
            owed[i] += FU_CREDITS;
            auto_ret[i] = 1'b1;
        end
        repeat (3) next_cycle();
    endtask

    initial begin
        void'($urandom(32'hf43be83f));
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_pkt   = '0;
        alu_credit  = 1'b0;
        lsq_credit  = 1'b0;
        bra_credit  = 1'b0;
        next_pc     = 32'h0000_1000;
        sent        = 0;
        returned    = 0;
        ill_seen    = 0;
        for (int i = 0; i < 3; i++) begin
            seen[i]     = 0;
            owed[i]     = 0;
            auto_ret[i] = 1'b1;
        end
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;

        idle_test();
        alu_test();
        lsq_test();
        branch_test();
        backpressure_test();
        illegal_test();

        test_name = "final";
        check_count("fetch credits returned overall", sent, returned);
        if (u_dut.u_checker.fail_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run("Assertions in the bound checker failed");
        end
    end

endmodule

`default_nettype wire

//--- bench/decode_dispatch_checker.sv
`default_nettype none

module decode_dispatch_checker (
    input logic       clk,
    input logic       rst,
    input logic       fetch_credit,
    input logic       head_valid,
    input logic       alu_valid,
    input logic       lsq_valid,
    input logic       bra_valid,
    input logic [2:0] cnt_nz
);

    // Count of failed assertions
    int fail_count = 0;

    a_credit_needs_entry: assert property (@(posedge clk) disable iff (rst)
        fetch_credit |-> head_valid)
    else begin
        fail_count++;
        $error("fetch_credit pulsed while the decode queue was empty");
    end

    a_one_unit_valid: assert property (@(posedge clk) disable iff (rst)
        $onehot0({bra_valid, lsq_valid, alu_valid}))
    else begin
        fail_count++;
        $error("more than one function unit valid in the same cycle");
    end

    // Valid is registered, so the send happened a cycle earlier
    a_send_needs_credit: assert property (@(posedge clk) disable iff (rst)
        ({bra_valid, lsq_valid, alu_valid} & ~$past(cnt_nz)) == 3'b000)
    else begin
        fail_count++;
        $error("function unit valid raised while its credit counter was zero");
    end

endmodule

bind decode_dispatch_top decode_dispatch_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .fetch_credit (fetch_credit),
    .head_valid   (head_valid),
    .alu_valid    (alu_valid),
    .lsq_valid    (lsq_valid),
    .bra_valid    (bra_valid),
    .cnt_nz       (u_dispatch.cnt_nz)
);

`default_nettype wire

//--- source/decode_dispatch_top.sv
`default_nettype none

module decode_dispatch_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int FU_CREDITS  = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_valid,
    input  decode_pkg::fetch_pkt_t fetch_pkt,
    output logic                   fetch_credit,
    output logic                   alu_valid,
    output decode_pkg::uop_t       alu_uop,
    input  logic                   alu_credit,
    output logic                   lsq_valid,
    output decode_pkg::uop_t       lsq_uop,
    input  logic                   lsq_credit,
    output logic                   bra_valid,
    output decode_pkg::uop_t       bra_uop,
    input  logic                   bra_credit,
    output logic                   illegal_valid,
    output decode_pkg::xlen_t      illegal_pc
);
    import decode_pkg::*;

    logic dec_valid;
    uop_t dec_uop;
    logic head_valid;
    uop_t head_uop;
    logic pop;

    inst_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_pkt   (fetch_pkt),
        .dec_valid   (dec_valid),
        .dec_uop     (dec_uop)
    );

    decode_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk          (clk),
        .rst          (rst),
        .push         (dec_valid),
        .push_uop     (dec_uop),
        .pop          (pop),
        .head_valid   (head_valid),
        .head_uop     (head_uop),
        .fetch_credit (fetch_credit)
    );

    fu_dispatch #(
        .FU_CREDITS (FU_CREDITS)
    ) u_dispatch (
        .clk           (clk),
        .rst           (rst),
        .head_valid    (head_valid),
        .head_uop      (head_uop),
        .pop           (pop),
        .alu_credit    (alu_credit),
        .lsq_credit    (lsq_credit),
        .bra_credit    (bra_credit),
        .alu_valid     (alu_valid),
        .lsq_valid     (lsq_valid),
        .bra_valid     (bra_valid),
        .illegal_valid (illegal_valid),
        .alu_uop       (alu_uop),
        .lsq_uop       (lsq_uop),
        .bra_uop       (bra_uop),
        .illegal_pc    (illegal_pc)
    );

endmodule

`default_nettype wire

//--- source/fu_dispatch.sv
`default_nettype none

module fu_dispatch #(
    parameter int FU_CREDITS = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              head_valid,
    input  decode_pkg::uop_t  head_uop,
    output logic              pop,
    input  logic              alu_credit,
    input  logic              lsq_credit,
    input  logic              bra_credit,
    output logic              alu_valid,
    output logic              lsq_valid,
    output logic              bra_valid,
    output logic              illegal_valid,
    output decode_pkg::uop_t  alu_uop,
    output decode_pkg::uop_t  lsq_uop,
    output decode_pkg::uop_t  bra_uop,
    output decode_pkg::xlen_t illegal_pc
);
    import decode_pkg::*;

    localparam int CNT_W = $clog2(FU_CREDITS + 1);

    // Index 0 is ALU, 1 is LSQ, 2 is branch
    logic [CNT_W-1:0] credit_cnt [3];
    logic [2:0] credit_in;
    logic [2:0] cnt_nz;
    logic [2:0] unit_sel;
    logic [2:0] send;
    logic       is_illegal;

    assign credit_in = {bra_credit, lsq_credit, alu_credit};

    always_comb begin
        case (head_uop.fu)
            FU_ALU:  unit_sel = 3'b001;
            FU_LSQ:  unit_sel = 3'b010;
            FU_BRA:  unit_sel = 3'b100;
            default: unit_sel = 3'b000;
        endcase
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            cnt_nz[i] = (credit_cnt[i] != '0);
        end
    end

    // A stalled head holds back everything behind it
    assign is_illegal = (head_uop.fu == FU_NONE);
    assign pop        = head_valid && (is_illegal || |(unit_sel & cnt_nz));
    assign send       = {3{pop}} & unit_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                credit_cnt[i] <= CNT_W'(FU_CREDITS);
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (send[i] && !credit_in[i]) begin
                    credit_cnt[i] <= credit_cnt[i] - 1'b1;
                end else if (credit_in[i] && !send[i]) begin
                    credit_cnt[i] <= credit_cnt[i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid     <= 1'b0;
            lsq_valid     <= 1'b0;
            bra_valid     <= 1'b0;
            illegal_valid <= 1'b0;
        end else begin
            alu_valid     <= send[0];
            lsq_valid     <= send[1];
            bra_valid     <= send[2];
            illegal_valid <= pop && is_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (send[0]) begin
            alu_uop <= head_uop;
        end
        if (send[1]) begin
            lsq_uop <= head_uop;
        end
        if (send[2]) begin
            bra_uop <= head_uop;
        end
        if (pop && is_illegal) begin
            illegal_pc <= head_uop.pc;
        end
    end

endmodule

`default_nettype wire

//--- source/decode_queue.sv
`default_nettype none

module decode_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  decode_pkg::uop_t push_uop,
    input  logic             pop,
    output logic             head_valid,
    output decode_pkg::uop_t head_uop,
    output logic             fetch_credit
);
    import decode_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    uop_t mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Wraps for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_uop;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_valid = (count != '0);
    assign head_uop   = mem[rd_ptr];

    // Each freed slot goes straight back to fetch
    assign fetch_credit = pop;

endmodule

`default_nettype wire

//--- source/inst_decoder.sv
`default_nettype none

module inst_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_valid,
    input  decode_pkg::fetch_pkt_t fetch_pkt,
    output logic                   dec_valid,
    output decode_pkg::uop_t       dec_uop
);
    import decode_pkg::*;

    inst_t   inst;
    opcode_t opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    logic is_r, is_load, is_logic, is_jalr, is_store, is_branch;
    logic is_lui, is_auipc, is_jal;

    xlen_t imm_i, imm_s, imm_b, imm_u, imm_j;
    fu_op_t alu_op, mem_op, bra_op;
    uop_t uop_next;

    assign inst   = fetch_pkt.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // Only the encodings of base RV32I are legal
    assign is_r      = (opcode == OPC_R) && ((funct7 == 7'h00) ||
                       ((funct7 == 7'h20) && ((funct3 == 3'h0) || (funct3 == 3'h5))));
    assign is_load   = (opcode == OPC_I_MEM) && (funct3 inside {3'h0, 3'h1, 3'h2, 3'h4, 3'h5});
    assign is_logic  = (opcode == OPC_I_LOGIC) &&
                       ((funct3 == 3'h1) ? (funct7 == 7'h00) :
                        ((funct3 != 3'h5) || (funct7 == 7'h00) || (funct7 == 7'h20)));
    assign is_jalr   = (opcode == OPC_JALR) && (funct3 == 3'h0);
    assign is_store  = (opcode == OPC_S) && (funct3 inside {3'h0, 3'h1, 3'h2});
    assign is_branch = (opcode == OPC_B) && (funct3 != 3'h2) && (funct3 != 3'h3);
    assign is_lui    = (opcode == OPC_LUI);
    assign is_auipc  = (opcode == OPC_AUIPC);
    assign is_jal    = (opcode == OPC_JAL);

    // Immediates by format
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'h000};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // addi ignores bit 30, which belongs to its immediate
    always_comb begin
        case (funct3)
            3'h0:    alu_op = (is_r && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'h1:    alu_op = ALU_SLL;
            3'h2:    alu_op = ALU_SLT;
            3'h3:    alu_op = ALU_SLTU;
            3'h4:    alu_op = ALU_XOR;
            3'h5:    alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'h6:    alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'h0:    mem_op = is_store ? MEM_SB : MEM_LB;
            3'h1:    mem_op = is_store ? MEM_SH : MEM_LH;
            3'h2:    mem_op = is_store ? MEM_SW : MEM_LW;
            3'h4:    mem_op = MEM_LBU;
            default: mem_op = MEM_LHU;
        endcase
    end

    always_comb begin
        case (funct3)
            3'h0:    bra_op = BRA_BEQ;
            3'h1:    bra_op = BRA_BNE;
            3'h4:    bra_op = BRA_BLT;
            3'h5:    bra_op = BRA_BGE;
            3'h6:    bra_op = BRA_BLTU;
            default: bra_op = BRA_BGEU;
        endcase
    end

    always_comb begin
        uop_next     = '0;
        uop_next.pc  = fetch_pkt.pc;
        uop_next.rd  = inst[11:7];
        uop_next.rs1 = inst[19:15];
        uop_next.rs2 = inst[24:20];
        if (is_r || is_logic) begin
            uop_next.fu        = FU_ALU;
            uop_next.fu_op     = alu_op;
            uop_next.reg_write = 1'b1;
            uop_next.op_a_sel  = OPSEL_REG;
            uop_next.op_b_sel  = is_r ? OPSEL_REG : OPSEL_IMM;
            uop_next.imm       = is_r ? '0 : imm_i;
        end else if (is_lui || is_auipc) begin
            uop_next.fu        = FU_ALU;
            uop_next.fu_op     = is_lui ? ALU_OUTB : ALU_ADD;
            uop_next.reg_write = 1'b1;
            uop_next.op_a_sel  = is_auipc ? OPSEL_PC : OPSEL_ZERO;
            uop_next.imm       = imm_u;
        end else if (is_load || is_store) begin
            uop_next.fu        = FU_LSQ;
            uop_next.fu_op     = mem_op;
            uop_next.reg_write = is_load;
            uop_next.op_a_sel  = OPSEL_REG;
            uop_next.imm       = is_load ? imm_i : imm_s;
        end else if (is_branch) begin
            uop_next.fu    = FU_BRA;
            uop_next.fu_op = bra_op;
            uop_next.imm   = imm_b;
        end else if (is_jal || is_jalr) begin
            uop_next.fu        = FU_BRA;
            uop_next.fu_op     = is_jal ? BRA_JAL : BRA_JALR;
            uop_next.reg_write = 1'b1;
            uop_next.imm       = is_jal ? imm_j : imm_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            dec_uop <= uop_next;
        end
    end

endmodule

`default_nettype wire

//--- source/decode_pkg.sv
`default_nettype none

package decode_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [1:0]  fu_type_t;
    typedef logic [3:0]  fu_op_t;
    typedef logic [1:0]  opsel_t;

    // Function unit kinds
    localparam fu_type_t FU_NONE = 2'd0;
    localparam fu_type_t FU_ALU  = 2'd1;
    localparam fu_type_t FU_LSQ  = 2'd2;
    localparam fu_type_t FU_BRA  = 2'd3;

    localparam fu_op_t ALU_ADD  = 4'd0;
    localparam fu_op_t ALU_SUB  = 4'd1;
    localparam fu_op_t ALU_AND  = 4'd2;
    localparam fu_op_t ALU_OR   = 4'd3;
    localparam fu_op_t ALU_XOR  = 4'd4;
    localparam fu_op_t ALU_SLL  = 4'd5;
    localparam fu_op_t ALU_SRL  = 4'd6;
    localparam fu_op_t ALU_SRA  = 4'd7;
    localparam fu_op_t ALU_SLT  = 4'd8;
    localparam fu_op_t ALU_SLTU = 4'd9;
    localparam fu_op_t ALU_OUTB = 4'd10;

    localparam fu_op_t MEM_LB  = 4'd0;
    localparam fu_op_t MEM_LH  = 4'd1;
    localparam fu_op_t MEM_LW  = 4'd2;
    localparam fu_op_t MEM_LBU = 4'd3;
    localparam fu_op_t MEM_LHU = 4'd4;
    localparam fu_op_t MEM_SB  = 4'd5;
    localparam fu_op_t MEM_SH  = 4'd6;
    localparam fu_op_t MEM_SW  = 4'd7;

    localparam fu_op_t BRA_BEQ  = 4'd0;
    localparam fu_op_t BRA_BNE  = 4'd1;
    localparam fu_op_t BRA_BLT  = 4'd2;
    localparam fu_op_t BRA_BGE  = 4'd3;
    localparam fu_op_t BRA_BLTU = 4'd4;
    localparam fu_op_t BRA_BGEU = 4'd5;
    localparam fu_op_t BRA_JAL  = 4'd6;
    localparam fu_op_t BRA_JALR = 4'd7;

    // PC and IMM share code 1, for operand A and B respectively
    localparam opsel_t OPSEL_ZERO = 2'd0;
    localparam opsel_t OPSEL_PC   = 2'd1;
    localparam opsel_t OPSEL_IMM  = 2'd1;
    localparam opsel_t OPSEL_REG  = 2'd2;

    localparam opcode_t OPC_R       = 7'b0110011;
    localparam opcode_t OPC_I_MEM   = 7'b0000011;
    localparam opcode_t OPC_I_LOGIC = 7'b0010011;
    localparam opcode_t OPC_JALR    = 7'b1100111;
    localparam opcode_t OPC_S       = 7'b0100011;
    localparam opcode_t OPC_B       = 7'b1100011;
    localparam opcode_t OPC_LUI     = 7'b0110111;
    localparam opcode_t OPC_AUIPC   = 7'b0010111;
    localparam opcode_t OPC_JAL     = 7'b1101111;

    typedef struct packed {
        xlen_t pc;
        inst_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        xlen_t    pc;
        fu_type_t fu;
        fu_op_t   fu_op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    imm;
        logic     reg_write;
        opsel_t   op_a_sel;
        opsel_t   op_b_sel;
    } uop_t;

endpackage

`default_nettype wire
